// File: common/fpu_cfg.svh
/*
 * FPU configuration constants
 * word and opcode widths, opcode bit positions, restored operand
 * widths and the float-to-int opcode
 */

`ifndef FPU_CFG_SVH
`define FPU_CFG_SVH

// datapath widths
`define FPU_WORD_W        32   // operand and result word
`define FPU_OP_W          8    // opcode from decode

// opcode bit positions
`define FPU_OP_VALID_BIT  7    // set for any fpu instruction
`define FPU_OP_UNORD_BIT  4    // unordered compare variant
`define FPU_OP_CMP_BIT    3    // compare family

// restored operand fields
`define FPU_EXP10_W       10   // exponent with headroom
`define FPU_SIG_W         24   // significand incl hidden bit

// arithmetic codes in bits 2:0
`define FPU_F2I_CODE      3'd5 // float to int32

`endif

// File: common/fpu_op_pkg.sv
/*
 * FPU opcode types
 * opcode word layout as sent by decode and the compare predicate
 * carried in the low opcode bits
 */

`default_nettype none

`include "fpu_cfg.svh"

package fpu_op_pkg;

  // predicate in bits 2:0 when the compare bit is set
  typedef enum logic [2:0] {
    EQ = 3'd0,
    NE = 3'd1,
    GT = 3'd2,
    GE = 3'd3,
    LT = 3'd4,
    LE = 3'd5   // 6 and 7 unused, flag reads false
  } cmp_pred_e;

  // opcode as seen by the fpu
  typedef struct packed {
    logic                    valid;  // fpu instruction marker
    logic [`FPU_OP_W-7:0]    spare;  // reserved, ignored
    logic                    unord;  // unordered compare
    logic                    cmp;    // compare family
    logic [2:0]              code;   // predicate or arith code
  } fpu_op_t;

endpackage

`default_nettype wire

// File: common/fp32_fmt_pkg.sv
/*
 * binary32 format types
 * raw and field views of an ieee single word, the per-operand class
 * record handed to the execution units, and the FPCSR flag word
 */

`default_nettype none

`include "fpu_cfg.svh"

package fp32_fmt_pkg;

  // one word, two decodes
  typedef union packed {
    logic [`FPU_WORD_W-1:0] raw;   // whole word
    struct packed {
      logic        sign;
      logic [7:0]  exp;            // biased exponent
      logic [22:0] fract;          // stored fraction
    } fields;
  } fp32_word_u;

  // operand description after unpack
  typedef struct packed {
    logic                    sign;
    logic                    zero;   // +0 or -0
    logic                    dn;     // denormal
    logic                    inf;
    logic                    snan;   // signalling nan
    logic                    qnan;   // quiet nan
    logic [`FPU_EXP10_W-1:0] exp10;  // restored exponent
    logic [`FPU_SIG_W-1:0]   sig24;  // hidden bit restored
  } fp32_class_t;

  // exception flags
  typedef struct packed {
    logic ovf;   // conversion overflow
    logic inv;   // invalid operation
    logic snan;  // snan operand seen
    logic ix;    // inexact
    logic zero;  // integer result is 0
  } fpcsr_t;

endpackage

`default_nettype wire

// File: hw/fpu_issue_ctrl.sv
/*
 * FPU issue control
 * holds the decoded operation until the units advance and turns it
 * into a start for the compare unit or the f2i converter
 */

`timescale 1ns/1ns
`default_nettype none

`include "fpu_cfg.svh"

module fpu_issue_ctrl (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  flush_i,
  input  wire                  padv_decode_i,  // new op decoded
  input  wire                  adv_i,          // units advance
  input  fpu_op_pkg::fpu_op_t  op_i,
  output logic                 cmp_start_o,
  output logic                 f2i_start_o
);

  logic new_data;  // op waiting for capture
  logic is_fpu;
  logic is_cmp;
  logic issue;

  // pending flag, flush wins, decode beats advance
  always_ff @(posedge clk) begin
    if (rst) begin
      new_data <= 1'b0;
    end else if (flush_i) begin
      new_data <= 1'b0;
    end else if (padv_decode_i) begin
      new_data <= 1'b1;
    end else if (adv_i) begin
      new_data <= 1'b0;   // taken by a unit
    end
  end

  assign is_fpu = op_i[`FPU_OP_VALID_BIT];
  assign is_cmp = op_i[`FPU_OP_CMP_BIT];
  assign issue  = new_data & is_fpu;

  // one start per op, other codes start nothing
  assign cmp_start_o = issue & is_cmp;
  assign f2i_start_o = issue & ~is_cmp & (op_i.code == `FPU_F2I_CODE);

endmodule

`default_nettype wire

// File: hw/fp32_operand_unpack.sv
/*
 * binary32 operand unpack
 * classifies both operands and restores exponent and significand,
 * purely combinational
 */

`timescale 1ns/1ns
`default_nettype none

module fp32_operand_unpack (
  input  fp32_fmt_pkg::fp32_word_u   a_i,
  input  fp32_fmt_pkg::fp32_word_u   b_i,
  output fp32_fmt_pkg::fp32_class_t  a_cls_o,
  output fp32_fmt_pkg::fp32_class_t  b_cls_o
);

  // same decode for either operand
  function automatic fp32_fmt_pkg::fp32_class_t classify(
    input fp32_fmt_pkg::fp32_word_u w
  );
    fp32_fmt_pkg::fp32_class_t c;
    logic exp_ff;
    logic frac_nz;
    exp_ff  = &w.fields.exp;
    frac_nz = |w.fields.fract;
    c.sign  = w.fields.sign;
    c.zero  = ~(|w.raw[30:0]);                    // ignores sign
    c.dn    = ~(|w.fields.exp) & frac_nz;
    c.inf   = exp_ff & ~frac_nz;
    c.snan  = exp_ff & ~w.fields.fract[22] & (|w.fields.fract[21:0]);
    c.qnan  = exp_ff & w.fields.fract[22];        // msb of fraction
    // denormal scales like exponent 1
    c.exp10 = {2'd0, w.fields.exp[7:1], w.fields.exp[0] | c.dn};
    c.sig24 = {~c.dn & ~c.zero, w.fields.fract};  // hidden bit
    return c;
  endfunction

  assign a_cls_o = classify(a_i);
  assign b_cls_o = classify(b_i);

endmodule

`default_nettype wire

// File: hw/fpu_cmp/fp32_cmp.sv
/*
 * binary32 comparator
 * magnitude and sign compare with +0 == -0, predicate select with
 * ordered and unordered nan rules, one register stage
 */

`timescale 1ns/1ns
`default_nettype none

module fp32_cmp (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        flush_i,
  input  wire                        adv_i,
  input  wire                        start_i,
  input  fpu_op_pkg::cmp_pred_e      pred_i,
  input  wire                        unord_i,   // unordered variant
  input  fp32_fmt_pkg::fp32_class_t  a_i,
  input  fp32_fmt_pkg::fp32_class_t  b_i,
  output logic                       cmp_flag_o,
  output logic                       inv_o,
  output logic                       snan_o,
  output logic                       rdy_o
);

  logic any_snan, any_nan;
  logic both_zero;
  logic mag_gt, mag_eq;
  logic eq, gt, lt;
  logic rel_pred;
  logic flag_d, inv_d;

  assign any_snan  = a_i.snan | b_i.snan;
  assign any_nan   = any_snan | a_i.qnan | b_i.qnan;
  assign both_zero = a_i.zero & b_i.zero;   // +0 vs -0

  // magnitude as {exp, sig}, inf sorts above finite
  assign mag_gt = {a_i.exp10, a_i.sig24} > {b_i.exp10, b_i.sig24};
  assign mag_eq = {a_i.exp10, a_i.sig24} == {b_i.exp10, b_i.sig24};

  assign eq = both_zero | ((a_i.sign == b_i.sign) & mag_eq);
  assign gt = ~both_zero & ((a_i.sign != b_i.sign) ? ~a_i.sign :
                            (a_i.sign ? (~mag_gt & ~mag_eq) : mag_gt));
  assign lt = ~gt & ~eq;

  assign rel_pred = pred_i inside {fpu_op_pkg::GT, fpu_op_pkg::GE,
                                   fpu_op_pkg::LT, fpu_op_pkg::LE};

  //////////////////////////////
  // predicate select
  //////////////////////////////
  always_comb begin
    case (pred_i)
      fpu_op_pkg::EQ: flag_d = eq;
      fpu_op_pkg::NE: flag_d = ~eq;
      fpu_op_pkg::GT: flag_d = gt;
      fpu_op_pkg::GE: flag_d = gt | eq;
      fpu_op_pkg::LT: flag_d = lt;
      fpu_op_pkg::LE: flag_d = lt | eq;
      default:        flag_d = 1'b0;    // codes 6, 7
    endcase
    if (any_nan && rel_pred) begin
      flag_d = unord_i;                 // ordered false, unordered true
    end else if (any_nan && pred_i == fpu_op_pkg::EQ) begin
      flag_d = unord_i;
    end else if (any_nan && pred_i == fpu_op_pkg::NE) begin
      flag_d = 1'b1;                    // ne true either way
    end
  end

  // snan always invalid, qnan only for ordered relations
  assign inv_d = any_snan | (any_nan & ~unord_i & rel_pred);

  always_ff @(posedge clk) begin
    if (rst) begin
      rdy_o <= 1'b0;
    end else if (flush_i) begin
      rdy_o <= 1'b0;
    end else if (adv_i) begin
      rdy_o <= start_i;
    end
  end

  always_ff @(posedge clk) begin
    if (adv_i) begin
      cmp_flag_o <= flag_d;
      inv_o      <= inv_d;
      snan_o     <= any_snan;
    end
  end

endmodule

`default_nettype wire

// File: hw/fpu_f2i/fp32_f2i.sv
/*
 * binary32 to int32 converter
 * truncates toward zero, saturates on overflow and nan
 * stage 1: shift decision and special cases
 * stage 2: shift, negate, saturate and flags
 */

`timescale 1ns/1ns
`default_nettype none

`include "fpu_cfg.svh"

module fp32_f2i (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        flush_i,
  input  wire                        adv_i,
  input  wire                        start_i,
  input  fp32_fmt_pkg::fp32_class_t  a_i,
  output logic [`FPU_WORD_W-1:0]     int_o,
  output logic                       ovf_o,
  output logic                       inv_o,
  output logic                       snan_o,
  output logic                       ix_o,
  output logic                       rdy_o
);

  logic signed [10:0]        exp_unb;    // exp10 - bias
  logic signed [10:0]        shr_amt;
  logic signed [10:0]        shl_amt;
  logic                      shr_d, ovf_d, nan_d;
  logic [4:0]                amt_d;
  logic                      s1_valid, s1_sign, s1_shr, s1_ovf, s1_nan, s1_snan;
  logic [4:0]                s1_amt;
  logic [`FPU_SIG_W-1:0]     s1_sig24;
  logic [2*`FPU_SIG_W-1:0]   shr_ext;    // int part : dropped bits
  logic [`FPU_WORD_W-1:0]    mag, int_d;
  logic                      ix_d;

  //////////////////////////////
  // stage 1
  //////////////////////////////
  assign exp_unb = $signed({1'b0, a_i.exp10}) - 11'sd127;
  assign shr_amt = 11'sd23 - exp_unb;
  assign shl_amt = exp_unb - 11'sd23;
  assign nan_d   = a_i.snan | a_i.qnan;
  assign shr_d   = exp_unb < 11'sd24;                   // fraction to drop
  assign amt_d   = exp_unb[10] ? 5'd24 :                // |x| < 1, all gone
                   (shr_d ? shr_amt[4:0] : shl_amt[4:0]);
  // -2^31 exactly fits
  assign ovf_d   = ~nan_d & ((exp_unb > 11'sd31) |
                   ((exp_unb == 11'sd31) & ~(a_i.sign & (a_i.sig24 == 24'h800000))));

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else if (flush_i) begin
      s1_valid <= 1'b0;
    end else if (adv_i) begin
      s1_valid <= start_i;
    end
  end

  always_ff @(posedge clk) begin
    if (adv_i) begin
      s1_sign  <= a_i.sign;
      s1_shr   <= shr_d;
      s1_amt   <= amt_d;
      s1_sig24 <= a_i.sig24;
      s1_ovf   <= ovf_d;
      s1_nan   <= nan_d;
      s1_snan  <= a_i.snan;
    end
  end

  //////////////////////////////
  // stage 2
  //////////////////////////////
  assign shr_ext = {s1_sig24, {`FPU_SIG_W{1'b0}}} >> s1_amt;
  assign mag     = s1_shr ? {8'd0, shr_ext[2*`FPU_SIG_W-1:`FPU_SIG_W]} :
                            ({8'd0, s1_sig24} << s1_amt);  // at most 8
  assign ix_d    = s1_shr & (|shr_ext[`FPU_SIG_W-1:0]) & ~s1_nan & ~s1_ovf;

  always_comb begin
    if (s1_nan) begin
      int_d = 32'h7fff_ffff;
    end else if (s1_ovf) begin
      int_d = s1_sign ? 32'h8000_0000 : 32'h7fff_ffff;   // saturate
    end else begin
      int_d = s1_sign ? (~mag + 32'd1) : mag;            // two's complement
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rdy_o <= 1'b0;
    end else if (flush_i) begin
      rdy_o <= 1'b0;
    end else if (adv_i) begin
      rdy_o <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (adv_i) begin
      int_o  <= int_d;
      ovf_o  <= s1_ovf;
      inv_o  <= s1_nan;    // any nan is invalid
      snan_o <= s1_snan;
      ix_o   <= ix_d;
    end
  end

endmodule

`default_nettype wire

// File: hw/fpu_result_stage.sv
/*
 * FPU result stage
 * registers the ready unit's result into the core-facing outputs,
 * builds FPCSR, holds under back-pressure, drives unit advance
 */

`timescale 1ns/1ns
`default_nettype none

`include "fpu_cfg.svh"

module fpu_result_stage (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     flush_i,
  input  wire                     padv_execute_i,
  input  wire                     cmp_flag_i,
  input  wire                     cmp_inv_i,
  input  wire                     cmp_snan_i,
  input  wire                     cmp_rdy_i,
  input  wire [`FPU_WORD_W-1:0]   f2i_int_i,
  input  wire                     f2i_ovf_i,
  input  wire                     f2i_inv_i,
  input  wire                     f2i_snan_i,
  input  wire                     f2i_ix_i,
  input  wire                     f2i_rdy_i,
  output logic                    adv_o,
  output logic [`FPU_WORD_W-1:0]  fpu_result_o,
  output logic                    fpu_arith_valid_o,
  output logic                    fpu_cmp_flag_o,
  output logic                    fpu_cmp_valid_o,
  output fp32_fmt_pkg::fpcsr_t    fpcsr_o
);

  fp32_fmt_pkg::fpcsr_t csr_d;

  // move on when execute takes the result or nothing is held
  assign adv_o = padv_execute_i | ~(fpu_arith_valid_o | fpu_cmp_valid_o);

  // both units may finish together, flags merge
  always_comb begin
    csr_d      = '0;
    csr_d.ovf  = f2i_rdy_i & f2i_ovf_i;
    csr_d.inv  = (cmp_rdy_i & cmp_inv_i) | (f2i_rdy_i & f2i_inv_i);
    csr_d.snan = (cmp_rdy_i & cmp_snan_i) | (f2i_rdy_i & f2i_snan_i);
    csr_d.ix   = f2i_rdy_i & f2i_ix_i;
    csr_d.zero = f2i_rdy_i & (f2i_int_i == '0);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fpu_arith_valid_o <= 1'b0;
      fpu_cmp_valid_o   <= 1'b0;
      fpcsr_o           <= '0;
    end else if (flush_i) begin
      fpu_arith_valid_o <= 1'b0;
      fpu_cmp_valid_o   <= 1'b0;
    end else if (adv_o) begin
      fpu_arith_valid_o <= f2i_rdy_i;     // drops if nothing new
      fpu_cmp_valid_o   <= cmp_rdy_i;
      if (cmp_rdy_i | f2i_rdy_i) begin
        fpcsr_o <= csr_d;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (adv_o & cmp_rdy_i) begin
      fpu_cmp_flag_o <= cmp_flag_i;
    end
    if (adv_o & f2i_rdy_i) begin
      fpu_result_o <= f2i_int_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/fpu_top.sv
/*
 * single-precision FPU front end
 * issue control, operand unpack, compare and float-to-int paths,
 * result stage
 */

`timescale 1ns/1ns
`default_nettype none

`include "fpu_cfg.svh"

module fpu_top (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       flush_i,
  input  wire                       padv_decode_i,
  input  wire                       padv_execute_i,
  input  fpu_op_pkg::fpu_op_t       op_fpu_i,
  input  fp32_fmt_pkg::fp32_word_u  rfa_i,
  input  fp32_fmt_pkg::fp32_word_u  rfb_i,
  output logic [`FPU_WORD_W-1:0]    fpu_result_o,
  output logic                      fpu_arith_valid_o,
  output logic                      fpu_cmp_flag_o,
  output logic                      fpu_cmp_valid_o,
  output fp32_fmt_pkg::fpcsr_t      fpcsr_o
);

  fp32_fmt_pkg::fp32_class_t a_cls, b_cls;
  logic                      adv;                   // unit advance
  logic                      cmp_start, f2i_start;
  logic                      cmp_flag, cmp_inv, cmp_snan, cmp_rdy;
  logic [`FPU_WORD_W-1:0]    f2i_int;
  logic                      f2i_ovf, f2i_inv, f2i_snan, f2i_ix, f2i_rdy;

  fpu_issue_ctrl u_issue (
    .clk           (clk),
    .rst           (rst),
    .flush_i       (flush_i),
    .padv_decode_i (padv_decode_i),
    .adv_i         (adv),
    .op_i          (op_fpu_i),
    .cmp_start_o   (cmp_start),
    .f2i_start_o   (f2i_start)
  );

  fp32_operand_unpack u_unpack (
    .a_i     (rfa_i),
    .b_i     (rfb_i),
    .a_cls_o (a_cls),
    .b_cls_o (b_cls)
  );

  fp32_cmp u_cmp (
    .clk        (clk),
    .rst        (rst),
    .flush_i    (flush_i),
    .adv_i      (adv),
    .start_i    (cmp_start),
    .pred_i     (fpu_op_pkg::cmp_pred_e'(op_fpu_i.code)),
    .unord_i    (op_fpu_i[`FPU_OP_UNORD_BIT]),
    .a_i        (a_cls),
    .b_i        (b_cls),
    .cmp_flag_o (cmp_flag),
    .inv_o      (cmp_inv),
    .snan_o     (cmp_snan),
    .rdy_o      (cmp_rdy)
  );

  fp32_f2i u_f2i (
    .clk     (clk),
    .rst     (rst),
    .flush_i (flush_i),
    .adv_i   (adv),
    .start_i (f2i_start),
    .a_i     (a_cls),       // converts operand a only
    .int_o   (f2i_int),
    .ovf_o   (f2i_ovf),
    .inv_o   (f2i_inv),
    .snan_o  (f2i_snan),
    .ix_o    (f2i_ix),
    .rdy_o   (f2i_rdy)
  );

  fpu_result_stage u_result (
    .clk               (clk),
    .rst               (rst),
    .flush_i           (flush_i),
    .padv_execute_i    (padv_execute_i),
    .cmp_flag_i        (cmp_flag),
    .cmp_inv_i         (cmp_inv),
    .cmp_snan_i        (cmp_snan),
    .cmp_rdy_i         (cmp_rdy),
    .f2i_int_i         (f2i_int),
    .f2i_ovf_i         (f2i_ovf),
    .f2i_inv_i         (f2i_inv),
    .f2i_snan_i        (f2i_snan),
    .f2i_ix_i          (f2i_ix),
    .f2i_rdy_i         (f2i_rdy),
    .adv_o             (adv),
    .fpu_result_o      (fpu_result_o),
    .fpu_arith_valid_o (fpu_arith_valid_o),
    .fpu_cmp_flag_o    (fpu_cmp_flag_o),
    .fpu_cmp_valid_o   (fpu_cmp_valid_o),
    .fpcsr_o           (fpcsr_o)
  );

endmodule

`default_nettype wire

// File: testbench/fpu_ref_model.svh
/*
 * FPU reference model
 * ieee single compare predicates with nan rules and float to int32
 * conversion with truncation toward zero and saturation
 */

`ifndef FPU_REF_MODEL_SVH
`define FPU_REF_MODEL_SVH

function automatic logic is_nan(input logic [31:0] w);
  return (w[30:23] == 8'hff) && (w[22:0] != 23'd0);
endfunction

function automatic logic is_snan(input logic [31:0] w);
  return is_nan(w) && !w[22];  // quiet bit clear
endfunction

// sign-magnitude word as a signed key, +0 and -0 both map to 0
function automatic longint order_key(input logic [31:0] w);
  longint m;
  m = longint'(w[30:0]);
  return w[31] ? -m : m;
endfunction

function automatic logic ref_cmp_flag(input logic [2:0] pred, input logic unord,
                                      input logic [31:0] a, input logic [31:0] b);
  longint ka;
  longint kb;
  ka = order_key(a);
  kb = order_key(b);
  if (pred > 3'd5) return 1'b0;             // unused predicates
  if (is_nan(a) || is_nan(b)) begin
    return (pred == fpu_op_pkg::NE) ? 1'b1 : unord;
  end
  case (pred)
    fpu_op_pkg::EQ: return ka == kb;
    fpu_op_pkg::NE: return ka != kb;
    fpu_op_pkg::GT: return ka > kb;
    fpu_op_pkg::GE: return ka >= kb;
    fpu_op_pkg::LT: return ka < kb;
    default:        return ka <= kb;        // LE
  endcase
endfunction

function automatic fp32_fmt_pkg::fpcsr_t ref_cmp_csr(input logic [2:0] pred,
                                                    input logic unord,
                                                    input logic [31:0] a,
                                                    input logic [31:0] b);
  fp32_fmt_pkg::fpcsr_t c;
  logic any_nan;
  logic any_snan;
  logic relational;
  c          = '0;
  any_snan   = is_snan(a) || is_snan(b);
  any_nan    = is_nan(a) || is_nan(b);
  relational = (pred >= 3'd2) && (pred <= 3'd5);  // GT GE LT LE
  c.inv      = any_snan | (any_nan & ~unord & relational);
  c.snan     = any_snan;
  return c;
endfunction

task automatic ref_f2i(input logic [31:0] w, output logic [31:0] res,
                       output fp32_fmt_pkg::fpcsr_t csr);
  logic        s;
  logic [7:0]  e;
  logic [22:0] f;
  logic [63:0] scaled;  // value times 2^23
  logic [63:0] mag;
  logic        ovf;
  int          unb;
  s   = w[31];
  e   = w[30:23];
  f   = w[22:0];
  csr = '0;
  res = 32'd0;
  ovf = 1'b0;
  if (is_nan(w)) begin
    res      = 32'h7fff_ffff;
    csr.inv  = 1'b1;
    csr.snan = is_snan(w);
  end else if (e == 8'hff) begin
    ovf = 1'b1;                              // infinity
  end else if (e == 8'd0) begin
    csr.ix = (f != 23'd0);                   // zero or denormal, |x| < 1
  end else begin
    unb = int'(e) - 127;
    if (unb > 31) begin
      ovf = 1'b1;
    end else if (unb < 0) begin
      csr.ix = 1'b1;                         // nonzero below one
    end else begin
      scaled = {40'd0, 1'b1, f} << unb;
      mag    = scaled >> 23;
      csr.ix = |scaled[22:0];
      if ((!s && mag > 64'h7fff_ffff) || (s && mag > 64'h8000_0000)) begin
        ovf = 1'b1;
      end else begin
        res = s ? (32'd0 - mag[31:0]) : mag[31:0];
      end
    end
  end
  if (ovf) begin
    csr.ovf = 1'b1;
    csr.ix  = 1'b0;
    res     = s ? 32'h8000_0000 : 32'h7fff_ffff;
  end
  csr.zero = (res == 32'd0);
endtask

`endif

// File: testbench/tb_fpu_top.sv
/*
 * FPU front end testbench
 * random compare and float-to-int ops checked against a reference
 * model, plus latency, back-pressure, flush and unknown opcodes
 */

`timescale 1ns/1ns
`default_nettype none

`include "fpu_cfg.svh"

module tb_fpu_top;

  `include "fpu_ref_model.svh"

  localparam int CMP_EDGES = 2;    // edges after the decode edge
  localparam int F2I_EDGES = 3;
  localparam int WAIT_MAX  = 20;   // cycles before a wait gives up
  localparam int QUIET_WIN = 10;   // cycles watched for a stray valid
  localparam int N_OPS     = 400;

  logic                      clk;
  logic                      rst;
  logic                      flush_i;
  logic                      padv_decode;
  logic                      padv_execute;
  fpu_op_pkg::fpu_op_t       op_fpu;
  fp32_fmt_pkg::fp32_word_u  rfa;
  fp32_fmt_pkg::fp32_word_u  rfb;
  logic [`FPU_WORD_W-1:0]    fpu_result;
  logic                      fpu_arith_valid;
  logic                      fpu_cmp_flag;
  logic                      fpu_cmp_valid;
  fp32_fmt_pkg::fpcsr_t      fpcsr;
  int                        err_val;    // wrong values
  int                        err_other;  // timeouts, latency, stray valids

  fpu_top u_dut (
    .clk               (clk),
    .rst               (rst),
    .flush_i           (flush_i),
    .padv_decode_i     (padv_decode),
    .padv_execute_i    (padv_execute),
    .op_fpu_i          (op_fpu),
    .rfa_i             (rfa),
    .rfb_i             (rfb),
    .fpu_result_o      (fpu_result),
    .fpu_arith_valid_o (fpu_arith_valid),
    .fpu_cmp_flag_o    (fpu_cmp_flag),
    .fpu_cmp_valid_o   (fpu_cmp_valid),
    .fpcsr_o           (fpcsr)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;  // 40 ns period

  //////////////////////////////
  // compare tasks
  //////////////////////////////
  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      err_val++;
      $display("ERR %0t %s got %b exp %b", $time, name, got, want);
    end
  endtask

  task automatic check_int(input string name, input logic [`FPU_WORD_W-1:0] got,
                           input logic [`FPU_WORD_W-1:0] want);
    if (got !== want) begin
      err_val++;
      $display("ERR %0t %s got %h exp %h", $time, name, got, want);
    end
  endtask

  task automatic check_fpcsr(input string name, input fp32_fmt_pkg::fpcsr_t got,
                             input fp32_fmt_pkg::fpcsr_t want);
    if (got !== want) begin
      err_val++;
      $display("ERR %0t %s got %b exp %b", $time, name, got, want);
    end
  endtask

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////
  // biased toward special values
  function automatic fp32_fmt_pkg::fp32_word_u rand_operand();
    fp32_fmt_pkg::fp32_word_u w;
    int kind;
    kind           = $urandom_range(0, 11);
    w.fields.sign  = 1'($urandom_range(0, 1));
    w.fields.fract = 23'($urandom());
    w.fields.exp   = 8'($urandom_range(110, 165));  // around the int range
    case (kind)
      0: begin
        w.fields.exp   = 8'd0;           // signed zero
        w.fields.fract = 23'd0;
      end
      1: begin
        w.fields.exp = 8'd0;             // denormal
        if (w.fields.fract == 23'd0) w.fields.fract = 23'd1;
      end
      2: begin
        w.fields.exp   = 8'hff;          // infinity
        w.fields.fract = 23'd0;
      end
      3: begin
        w.fields.exp       = 8'hff;      // snan
        w.fields.fract[22] = 1'b0;
        if (w.fields.fract[21:0] == 22'd0) w.fields.fract[0] = 1'b1;
      end
      4: begin
        w.fields.exp       = 8'hff;      // qnan
        w.fields.fract[22] = 1'b1;
      end
      5: w.fields.exp = 8'($urandom_range(157, 158));  // near 2^31
      6: begin
        w.fields.exp   = 8'd158;         // exactly 2^31
        w.fields.fract = 23'd0;
      end
      7: w.fields.exp = 8'($urandom_range(1, 254));
      default: ;
    endcase
    return w;
  endfunction

  task automatic issue_op(input fpu_op_pkg::fpu_op_t op,
                          input fp32_fmt_pkg::fp32_word_u a,
                          input fp32_fmt_pkg::fp32_word_u b);
    @(posedge clk);
    #2;
    op_fpu      = op;
    rfa         = a;   // held until the next op
    rfb         = b;
    padv_decode = 1'b1;
    @(posedge clk);    // decode edge
    #2;
    padv_decode = 1'b0;
  endtask

  task automatic wait_result(input bit want_cmp, output int edges, output bit seen);
    edges = 0;
    seen  = 1'b0;
    while (!seen && edges < WAIT_MAX) begin
      @(posedge clk);
      #2;
      edges++;
      seen = want_cmp ? fpu_cmp_valid : fpu_arith_valid;
    end
  endtask

  task automatic flush_pipeline();
    @(posedge clk);
    #2;
    flush_i      = 1'b1;
    padv_decode  = 1'b0;
    padv_execute = 1'b0;
    @(posedge clk);
    #2;
    flush_i = 1'b0;
  endtask

  // no valid may show up in the window
  task automatic expect_quiet(input string what);
    int n;
    bit seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < QUIET_WIN) begin
      @(posedge clk);
      #2;
      n++;
      seen = fpu_cmp_valid | fpu_arith_valid;
    end
    if (seen) begin
      err_other++;
      $display("%s produced a valid result at %0t", what, $time);
      flush_pipeline();
    end
  endtask

  // outputs frozen while execute stalls and valid drops after release
  task automatic hold_and_release(input bit is_cmp, input logic want_flag,
                                  input logic [`FPU_WORD_W-1:0] want_res,
                                  input fp32_fmt_pkg::fpcsr_t want_csr);
    int n;
    n = $urandom_range(0, 5);
    repeat (n) begin
      @(posedge clk);
      #2;
      if (is_cmp) begin
        check_flag("fpu_cmp_valid_o", fpu_cmp_valid, 1'b1);
        check_flag("fpu_cmp_flag_o", fpu_cmp_flag, want_flag);
      end else begin
        check_flag("fpu_arith_valid_o", fpu_arith_valid, 1'b1);
        check_int("fpu_result_o", fpu_result, want_res);
      end
      check_fpcsr("fpcsr_o", fpcsr, want_csr);
    end
    padv_execute = 1'b1;
    @(posedge clk);
    #2;
    padv_execute = 1'b0;
    check_flag("fpu_cmp_valid_o", fpu_cmp_valid, 1'b0);
    check_flag("fpu_arith_valid_o", fpu_arith_valid, 1'b0);
  endtask

  //////////////////////////////
  // operations
  //////////////////////////////
  task automatic run_cmp(input logic [2:0] pred, input logic unord,
                         input fp32_fmt_pkg::fp32_word_u a,
                         input fp32_fmt_pkg::fp32_word_u b);
    fpu_op_pkg::fpu_op_t  op;
    logic                 want_flag;
    fp32_fmt_pkg::fpcsr_t want_csr;
    int                   edges;
    bit                   seen;
    op        = '0;
    op.valid  = 1'b1;
    op.cmp    = 1'b1;
    op.unord  = unord;
    op.code   = pred;
    want_flag = ref_cmp_flag(pred, unord, a.raw, b.raw);
    want_csr  = ref_cmp_csr(pred, unord, a.raw, b.raw);
    issue_op(op, a, b);
    wait_result(1'b1, edges, seen);
    if (!seen) begin
      err_other++;
      $display("compare result never became valid, a %h b %h", a.raw, b.raw);
      flush_pipeline();
    end else begin
      if (edges != CMP_EDGES) begin
        err_other++;
        $display("compare took %0d edges instead of %0d", edges, CMP_EDGES);
      end
      check_flag("fpu_cmp_flag_o", fpu_cmp_flag, want_flag);
      check_fpcsr("fpcsr_o", fpcsr, want_csr);
      check_flag("fpu_arith_valid_o", fpu_arith_valid, 1'b0);
      hold_and_release(1'b1, want_flag, '0, want_csr);
    end
  endtask

  task automatic run_f2i(input fp32_fmt_pkg::fp32_word_u a,
                         input fp32_fmt_pkg::fp32_word_u b);
    fpu_op_pkg::fpu_op_t    op;
    logic [`FPU_WORD_W-1:0] want_res;
    fp32_fmt_pkg::fpcsr_t   want_csr;
    int                     edges;
    bit                     seen;
    op       = '0;
    op.valid = 1'b1;
    op.code  = `FPU_F2I_CODE;
    ref_f2i(a.raw, want_res, want_csr);
    issue_op(op, a, b);    // b is ignored
    wait_result(1'b0, edges, seen);
    if (!seen) begin
      err_other++;
      $display("conversion result never became valid, a %h", a.raw);
      flush_pipeline();
    end else begin
      if (edges != F2I_EDGES) begin
        err_other++;
        $display("conversion took %0d edges instead of %0d", edges, F2I_EDGES);
      end
      check_int("fpu_result_o", fpu_result, want_res);
      check_fpcsr("fpcsr_o", fpcsr, want_csr);
      check_flag("fpu_cmp_valid_o", fpu_cmp_valid, 1'b0);
      hold_and_release(1'b0, 1'b0, want_res, want_csr);
    end
  endtask

  // flush lands somewhere between decode and the output register
  task automatic run_flush(input bit is_cmp, input fp32_fmt_pkg::fp32_word_u a);
    fpu_op_pkg::fpu_op_t op;
    int                  d;
    op       = '0;
    op.valid = 1'b1;
    op.cmp   = is_cmp;
    op.code  = is_cmp ? 3'($urandom_range(0, 5)) : `FPU_F2I_CODE;
    d        = $urandom_range(0, is_cmp ? CMP_EDGES : F2I_EDGES);
    @(posedge clk);
    #2;
    op_fpu      = op;
    rfa         = a;
    rfb         = a;
    padv_decode = 1'b1;
    repeat (d) begin
      @(posedge clk);
      #2;
      padv_decode = 1'b0;
    end
    flush_i = 1'b1;
    @(posedge clk);
    #2;
    flush_i     = 1'b0;
    padv_decode = 1'b0;
    expect_quiet("flushed op");
  endtask

  task automatic run_unknown(input fp32_fmt_pkg::fp32_word_u a);
    fpu_op_pkg::fpu_op_t op;
    op = '0;
    if ($urandom_range(0, 1) == 0) begin
      op.cmp  = 1'($urandom_range(0, 1));   // valid bit clear
      op.code = 3'($urandom_range(0, 7));
    end else begin
      op.valid = 1'b1;                      // arith code without a unit
      op.code  = 3'($urandom_range(0, 6));
      if (op.code == `FPU_F2I_CODE) op.code = 3'd7;
    end
    issue_op(op, a, a);
    expect_quiet("unknown opcode");
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    int                       i;
    int                       sel;
    fp32_fmt_pkg::fp32_word_u a;
    fp32_fmt_pkg::fp32_word_u b;
    void'($urandom(32'he236));
    err_val      = 0;
    err_other    = 0;
    rst          = 1'b1;
    flush_i      = 1'b0;
    padv_decode  = 1'b0;
    padv_execute = 1'b0;
    op_fpu       = '0;
    rfa          = '0;
    rfb          = '0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;

    for (i = 0; i < N_OPS; i++) begin
      sel = $urandom_range(0, 9);
      a   = rand_operand();
      b   = rand_operand();
      if ($urandom_range(0, 3) == 0) begin
        b = a;                               // equal pair
        if (a.raw[30:0] == 31'd0) b.fields.sign = 1'($urandom_range(0, 1));
      end
      if (sel <= 4) begin
        run_cmp(3'($urandom_range(0, 7)), 1'($urandom_range(0, 1)), a, b);
      end else if (sel <= 7) begin
        run_f2i(a, b);
      end else if (sel == 8) begin
        run_flush(1'($urandom_range(0, 1)), a);
      end else begin
        run_unknown(a);
      end
    end

    $display("errors: %0d wrong values, %0d other failures", err_val, err_other);
    if (err_val + err_other == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+common
+incdir+testbench
common/fpu_op_pkg.sv
common/fp32_fmt_pkg.sv
hw/fpu_issue_ctrl.sv
hw/fp32_operand_unpack.sv
hw/fpu_cmp/fp32_cmp.sv
hw/fpu_f2i/fp32_f2i.sv
hw/fpu_result_stage.sv
hw/fpu_top.sv
testbench/tb_fpu_top.sv

// File: Bender.yml
package:
  name: fpu_front

sources:
  - include_dirs:
      - common
    files:
      - common/fpu_op_pkg.sv
      - common/fp32_fmt_pkg.sv
      - hw/fpu_issue_ctrl.sv
      - hw/fp32_operand_unpack.sv
      - hw/fpu_cmp/fp32_cmp.sv
      - hw/fpu_f2i/fp32_f2i.sv
      - hw/fpu_result_stage.sv
      - hw/fpu_top.sv
  - target: simulation
    include_dirs:
      - common
      - testbench
    files:
      - testbench/tb_fpu_top.sv
